/* common/decode_ctrl_if.sv */
// Decoded fields are combinational from the current instruction and valid only with it
`timescale 1ns/10ps

interface decode_ctrl_if
  import rv32i_isa_pkg::*, dispatch_pkg::*;
();
  // Instruction fields
  opcode_t   opcode;
  reg_addr_t rs1, rs2, rd;

  // Sign-extended immediates and zero-extended shift amount
  word_t imm_i, imm_s, imm_b, imm_u, imm_j;
  word_t shamt;

  // Operand and write-back selects
  src_a_t src_a_sel;
  src_b_t src_b_sel;
  logic   imm_shamt_sel;
  logic   j_sel;
  wsrc_t  wsrc;

  // Execution control
  fu_t     fu;
  alu_op_t alu_op;
  logic    wen;
  logic    is_jump, is_branch;
  branch_t branch_type;
  logic    is_load, is_store, is_fence_i, illegal;

  modport decoder (
    output opcode, rs1, rs2, rd, imm_i, imm_s, imm_b, imm_u, imm_j, shamt,
           src_a_sel, src_b_sel, imm_shamt_sel, j_sel, wsrc, fu, alu_op, wen,
           is_jump, is_branch, branch_type, is_load, is_store, is_fence_i, illegal
  );

  modport operands (
    input src_a_sel, src_b_sel, imm_shamt_sel, j_sel, wsrc, shamt,
          imm_i, imm_s, imm_u, imm_j
  );

  modport dispatch (
    input rd, imm_b, fu, alu_op, wen, is_jump, is_branch, branch_type,
          is_load, is_store, illegal
  );

endinterface

/* common/decode_defines.svh */
// RV32I base opcodes only, and CB_AW must stay equal to log2 of CB_DEPTH
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// Datapath widths
`define XLEN   32
`define REG_AW 5

// Completion buffer
`define CB_DEPTH 16
`define CB_AW    4

// Base opcodes
`define OPC_LOAD     7'b0000011
`define OPC_MISC_MEM 7'b0001111
`define OPC_OP_IMM   7'b0010011
`define OPC_AUIPC    7'b0010111
`define OPC_STORE    7'b0100011
`define OPC_OP       7'b0110011
`define OPC_LUI      7'b0110111
`define OPC_BRANCH   7'b1100011
`define OPC_JALR     7'b1100111
`define OPC_JAL      7'b1101111

// MISC-MEM funct3 for fence.i
`define F3_FENCE_I 3'b001

`endif

/* common/dispatch_pkg.sv */
// Dispatch-side types for a single arithmetic unit and a load/store unit, no mul/div units
`include "decode_defines.svh"

package dispatch_pkg;

  // Target functional unit
  typedef enum logic [1:0] {
    FU_ARITH     = 2'd0,
    FU_LOADSTORE = 2'd1,
    FU_NONE      = 2'd2
  } fu_t;

  // Operand A source
  typedef enum logic [1:0] {
    SRCA_RS1   = 2'd0,
    SRCA_IMM_S = 2'd1,
    SRCA_PC    = 2'd2
  } src_a_t;

  // Operand B source
  typedef enum logic [1:0] {
    SRCB_RS1          = 2'd0,
    SRCB_RS2          = 2'd1,
    SRCB_IMM_OR_SHAMT = 2'd2,
    SRCB_IMM_U        = 2'd3
  } src_b_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_t;

  // Early write-back value
  typedef enum logic [1:0] {
    WSRC_NONE  = 2'd0,
    WSRC_PC4   = 2'd1,
    WSRC_IMM_U = 2'd2
  } wsrc_t;

  typedef logic [`CB_AW-1:0] cb_index_t;

endpackage

/* common/rv32i_isa_pkg.sv */
// Instruction-set types for RV32I only, and opcode_t has no encodings beyond the base set
`include "decode_defines.svh"

package rv32i_isa_pkg;

  // Data and address word
  typedef logic [`XLEN-1:0] word_t;

  // Architectural register number
  typedef logic [`REG_AW-1:0] reg_addr_t;

  // Raw 32-bit instruction
  typedef logic [31:0] instr_t;

  // Major opcodes, INVALID marks anything outside the decoded set
  typedef enum logic [6:0] {
    LOAD     = `OPC_LOAD,
    MISC_MEM = `OPC_MISC_MEM,
    OP_IMM   = `OPC_OP_IMM,
    AUIPC    = `OPC_AUIPC,
    STORE    = `OPC_STORE,
    OP       = `OPC_OP,
    LUI      = `OPC_LUI,
    BRANCH   = `OPC_BRANCH,
    JALR     = `OPC_JALR,
    JAL      = `OPC_JAL,
    INVALID  = 7'b0000000
  } opcode_t;

  // Branch condition, taken straight from funct3
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_t;

endpackage

/* decode/dispatch_latch.sv */
// Flush beats stall, and the tail only advances for instructions that reach a functional unit
`timescale 1ns/10ps
`include "decode_defines.svh"

module dispatch_latch
  import rv32i_isa_pkg::*, dispatch_pkg::*;
(
  input  logic            CLK,
  input  logic            nRST,
  input  logic            accept,
  input  logic            flush,
  input  logic            stall_ex,
  decode_ctrl_if.dispatch ctrl,
  input  word_t           next_port_a,
  input  word_t           next_port_b,
  input  word_t           next_wdata,
  input  word_t           next_j_base,
  input  word_t           next_j_offset,
  input  word_t           rs2_data,
  input  word_t           pc,
  output logic            dispatch_valid,
  output fu_t             fu,
  output alu_op_t         alu_op,
  output word_t           port_a,
  output word_t           port_b,
  output word_t           store_data,
  output word_t           br_imm,
  output reg_addr_t       rd,
  output logic            wen,
  output word_t           wdata,
  output logic            is_jump,
  output word_t           j_base,
  output word_t           j_offset,
  output logic            is_branch,
  output branch_t         branch_type,
  output logic            is_load,
  output logic            is_store,
  output logic            illegal,
  output cb_index_t       cb_index,
  output word_t           dispatch_pc
);

  cb_index_t tail;
  logic      clear;
  logic      alloc;

  // Bubble when nothing is taken and execute is not holding
  assign clear = flush | (~accept & ~stall_ex);
  // Fence and illegal instructions get no completion-buffer slot
  assign alloc = accept & (ctrl.fu != FU_NONE);

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      tail <= '0;
    end else if (alloc) begin
      if (tail == cb_index_t'(`CB_DEPTH - 1)) begin
        tail <= '0;
      end else begin
        tail <= tail + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      dispatch_valid <= 1'b0;
      fu             <= FU_NONE;
      alu_op         <= ALU_ADD;
      wen            <= 1'b0;
      is_jump        <= 1'b0;
      is_branch      <= 1'b0;
      branch_type    <= BEQ;
      is_load        <= 1'b0;
      is_store       <= 1'b0;
      illegal        <= 1'b0;
      cb_index       <= '0;
    end else if (clear) begin
      dispatch_valid <= 1'b0;
      fu             <= FU_NONE;
      alu_op         <= ALU_ADD;
      wen            <= 1'b0;
      is_jump        <= 1'b0;
      is_branch      <= 1'b0;
      branch_type    <= BEQ;
      is_load        <= 1'b0;
      is_store       <= 1'b0;
      illegal        <= 1'b0;
      cb_index       <= '0;
    end else if (accept) begin
      dispatch_valid <= 1'b1;
      fu             <= ctrl.fu;
      alu_op         <= ctrl.alu_op;
      wen            <= ctrl.wen;
      is_jump        <= ctrl.is_jump;
      is_branch      <= ctrl.is_branch;
      branch_type    <= ctrl.branch_type;
      is_load        <= ctrl.is_load;
      is_store       <= ctrl.is_store;
      illegal        <= ctrl.illegal;
      cb_index       <= tail;
    end
  end

  // Data fields
  always_ff @(posedge CLK) begin
    if (clear) begin
      port_a      <= '0;
      port_b      <= '0;
      store_data  <= '0;
      br_imm      <= '0;
      rd          <= '0;
      wdata       <= '0;
      j_base      <= '0;
      j_offset    <= '0;
      dispatch_pc <= '0;
    end else if (accept) begin
      port_a      <= next_port_a;
      port_b      <= next_port_b;
      store_data  <= rs2_data;
      br_imm      <= ctrl.imm_b;
      rd          <= ctrl.rd;
      wdata       <= next_wdata;
      j_base      <= next_j_base;
      j_offset    <= next_j_offset;
      dispatch_pc <= pc;
    end
  end

endmodule

/* decode/fence_tracker.sv */
// Back-to-back fence.i strobes flush once, and done pulses before a fence are ignored
`timescale 1ns/10ps

module fence_tracker (
  input  logic CLK,
  input  logic nRST,
  input  logic fence_seen,
  input  logic iflush_done,
  input  logic dflush_done,
  output logic cache_flush,
  output logic fence_busy
);

  logic last_fence;
  logic iflushed;
  logic dflushed;

  // Rising edge of fence.i over accepted strobes
  assign cache_flush = fence_seen & ~last_fence;
  assign fence_busy  = ~(iflushed & dflushed);

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      last_fence <= 1'b0;
    end else begin
      last_fence <= fence_seen;
    end
  end

  // Each cache acknowledges on its own
  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      iflushed <= 1'b1;
      dflushed <= 1'b1;
    end else if (cache_flush) begin
      iflushed <= 1'b0;
      dflushed <= 1'b0;
    end else begin
      iflushed <= iflushed | iflush_done;
      dflushed <= dflushed | dflush_done;
    end
  end

endmodule

/* decode/instr_decoder.sv */
// Base RV32I only, and a plain fence decodes to a no-op while a bad funct3 is not flagged
`timescale 1ns/10ps
`include "decode_defines.svh"

module instr_decoder
  import rv32i_isa_pkg::*, dispatch_pkg::*;
(
  input instr_t          instr,
  decode_ctrl_if.decoder ctrl
);

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       wen_op;
  alu_op_t    arith_op;

  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign ctrl.rs1 = instr[19:15];
  assign ctrl.rs2 = instr[24:20];
  assign ctrl.rd  = instr[11:7];

  // Immediate formats
  assign ctrl.imm_i = {{20{instr[31]}}, instr[31:20]};
  assign ctrl.imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign ctrl.imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign ctrl.imm_u = {instr[31:12], 12'b0};
  assign ctrl.imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  assign ctrl.shamt = word_t'(instr[24:20]);

  assign ctrl.branch_type = branch_t'(funct3);
  // Writes to x0 are dropped here
  assign ctrl.wen = wen_op & (ctrl.rd != '0);

  always_comb begin
    case (instr[6:0])
      `OPC_LOAD, `OPC_MISC_MEM, `OPC_OP_IMM, `OPC_AUIPC, `OPC_STORE,
      `OPC_OP, `OPC_LUI, `OPC_BRANCH, `OPC_JALR, `OPC_JAL:
        ctrl.opcode = opcode_t'(instr[6:0]);
      default:
        ctrl.opcode = INVALID;
    endcase
  end

  // SUB only exists in OP, SRA in both OP and OP-IMM
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (funct7[5] && ctrl.opcode == OP) ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = funct7[5] ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin
    ctrl.src_a_sel     = SRCA_RS1;
    ctrl.src_b_sel     = SRCB_RS2;
    ctrl.imm_shamt_sel = 1'b0;
    ctrl.j_sel         = 1'b0;
    ctrl.wsrc          = WSRC_NONE;
    ctrl.fu            = FU_ARITH;
    ctrl.alu_op        = ALU_ADD;
    wen_op             = 1'b0;
    ctrl.is_jump       = 1'b0;
    ctrl.is_branch     = 1'b0;
    ctrl.is_load       = 1'b0;
    ctrl.is_store      = 1'b0;
    ctrl.is_fence_i    = 1'b0;
    ctrl.illegal       = 1'b0;
    case (ctrl.opcode)
      OP: begin
        ctrl.alu_op = arith_op;
        wen_op      = 1'b1;
      end
      OP_IMM: begin
        ctrl.src_b_sel     = SRCB_IMM_OR_SHAMT;
        ctrl.imm_shamt_sel = (funct3 == 3'b001) || (funct3 == 3'b101);
        ctrl.alu_op        = arith_op;
        wen_op             = 1'b1;
      end
      LUI: begin
        ctrl.src_b_sel = SRCB_IMM_U;
        ctrl.wsrc      = WSRC_IMM_U;
        wen_op         = 1'b1;
      end
      AUIPC: begin
        ctrl.src_a_sel = SRCA_PC;
        ctrl.src_b_sel = SRCB_IMM_U;
        wen_op         = 1'b1;
      end
      JAL, JALR: begin
        ctrl.j_sel   = (ctrl.opcode == JAL);
        ctrl.wsrc    = WSRC_PC4;
        ctrl.is_jump = 1'b1;
        wen_op       = 1'b1;
      end
      BRANCH: ctrl.is_branch = 1'b1;
      LOAD: begin
        ctrl.src_b_sel = SRCB_IMM_OR_SHAMT;
        ctrl.fu        = FU_LOADSTORE;
        ctrl.is_load   = 1'b1;
        wen_op         = 1'b1;
      end
      STORE: begin
        // Address base from the S immediate, register base on port B
        ctrl.src_a_sel = SRCA_IMM_S;
        ctrl.src_b_sel = SRCB_RS1;
        ctrl.fu        = FU_LOADSTORE;
        ctrl.is_store  = 1'b1;
      end
      MISC_MEM: begin
        ctrl.fu         = FU_NONE;
        ctrl.is_fence_i = (funct3 == `F3_FENCE_I);
      end
      default: begin
        ctrl.fu      = FU_NONE;
        ctrl.illegal = 1'b1;
      end
    endcase
  end

endmodule

/* decode/operand_select.sv */
// Purely combinational, and operands follow register data in the same cycle
`timescale 1ns/10ps

module operand_select
  import rv32i_isa_pkg::*, dispatch_pkg::*;
(
  decode_ctrl_if.operands ctrl,
  input  word_t           rs1_data,
  input  word_t           rs2_data,
  input  word_t           pc,
  input  word_t           pc4,
  output word_t           port_a,
  output word_t           port_b,
  output word_t           wdata,
  output word_t           j_base,
  output word_t           j_offset
);

  word_t imm_or_shamt;

  // Shifts by immediate take the shamt field
  assign imm_or_shamt = ctrl.imm_shamt_sel ? ctrl.shamt : ctrl.imm_i;

  always_comb begin
    case (ctrl.src_a_sel)
      SRCA_RS1:   port_a = rs1_data;
      SRCA_IMM_S: port_a = ctrl.imm_s;
      SRCA_PC:    port_a = pc;
      default:    port_a = '0;
    endcase
  end

  always_comb begin
    case (ctrl.src_b_sel)
      SRCB_RS1:          port_b = rs1_data;
      SRCB_RS2:          port_b = rs2_data;
      SRCB_IMM_OR_SHAMT: port_b = imm_or_shamt;
      default:           port_b = ctrl.imm_u;
    endcase
  end

  always_comb begin
    case (ctrl.wsrc)
      WSRC_PC4:   wdata = pc4;
      WSRC_IMM_U: wdata = ctrl.imm_u;
      default:    wdata = '0;
    endcase
  end

  // JAL is pc-relative, JALR adds the I immediate to rs1
  assign j_base   = ctrl.j_sel ? pc : port_a;
  assign j_offset = ctrl.j_sel ? ctrl.imm_j : ctrl.imm_i;

endmodule

/* rtl/decode_stage.sv */
// Register file reads are combinational, and a strobe under stall_ex must be repeated upstream
`timescale 1ns/10ps

module decode_stage
  import rv32i_isa_pkg::*, dispatch_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  logic      instr_valid,
  input  instr_t    instr,
  input  word_t     pc,
  input  word_t     pc4,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  input  logic      flush,
  input  logic      stall_ex,
  input  logic      iflush_done,
  input  logic      dflush_done,
  output reg_addr_t rs1_addr,
  output reg_addr_t rs2_addr,
  output logic      dispatch_valid,
  output fu_t       fu,
  output alu_op_t   alu_op,
  output word_t     port_a,
  output word_t     port_b,
  output word_t     store_data,
  output word_t     br_imm,
  output reg_addr_t rd,
  output logic      wen,
  output word_t     wdata,
  output logic      is_jump,
  output word_t     j_base,
  output word_t     j_offset,
  output logic      is_branch,
  output branch_t   branch_type,
  output logic      is_load,
  output logic      is_store,
  output logic      illegal,
  output cb_index_t cb_index,
  output word_t     dispatch_pc,
  output logic      cache_flush,
  output logic      fence_busy
);

  decode_ctrl_if ctrl_if ();

  word_t sel_a;
  word_t sel_b;
  word_t sel_wdata;
  word_t sel_j_base;
  word_t sel_j_offset;
  logic  accept;
  logic  fence_seen;

  assign rs1_addr = ctrl_if.rs1;
  assign rs2_addr = ctrl_if.rs2;

  // fence.i goes to the cache tracker and never dispatches
  assign fence_seen = instr_valid & ~stall_ex & ctrl_if.is_fence_i;
  assign accept     = instr_valid & ~stall_ex & ~flush & ~ctrl_if.is_fence_i;

  instr_decoder u_decoder (
    .instr (instr),
    .ctrl  (ctrl_if.decoder)
  );

  operand_select u_operands (
    .ctrl     (ctrl_if.operands),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .pc       (pc),
    .pc4      (pc4),
    .port_a   (sel_a),
    .port_b   (sel_b),
    .wdata    (sel_wdata),
    .j_base   (sel_j_base),
    .j_offset (sel_j_offset)
  );

  dispatch_latch u_dispatch (
    .CLK            (CLK),
    .nRST           (nRST),
    .accept         (accept),
    .flush          (flush),
    .stall_ex       (stall_ex),
    .ctrl           (ctrl_if.dispatch),
    .next_port_a    (sel_a),
    .next_port_b    (sel_b),
    .next_wdata     (sel_wdata),
    .next_j_base    (sel_j_base),
    .next_j_offset  (sel_j_offset),
    .rs2_data       (rs2_data),
    .pc             (pc),
    .dispatch_valid (dispatch_valid),
    .fu             (fu),
    .alu_op         (alu_op),
    .port_a         (port_a),
    .port_b         (port_b),
    .store_data     (store_data),
    .br_imm         (br_imm),
    .rd             (rd),
    .wen            (wen),
    .wdata          (wdata),
    .is_jump        (is_jump),
    .j_base         (j_base),
    .j_offset       (j_offset),
    .is_branch      (is_branch),
    .branch_type    (branch_type),
    .is_load        (is_load),
    .is_store       (is_store),
    .illegal        (illegal),
    .cb_index       (cb_index),
    .dispatch_pc    (dispatch_pc)
  );

  fence_tracker u_fence (
    .CLK         (CLK),
    .nRST        (nRST),
    .fence_seen  (fence_seen),
    .iflush_done (iflush_done),
    .dflush_done (dflush_done),
    .cache_flush (cache_flush),
    .fence_busy  (fence_busy)
  );

endmodule

/* run.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module decode_stage_tb -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
  echo "Compile failed"
  exit 1
fi

./obj_dir/Vdecode_stage_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Test passed$" sim.log; then
  exit 0
fi
exit 1

/* verif/decode_vectors.svh */
// Only rows that are accepted use the expected control columns, and data values come from the model
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

// Columns: instr, valid, flush, stall_ex, iflush_done, dflush_done, fu, alu_op, flags
// Flags: F_WEN, F_JUMP, F_BRANCH, F_LOAD, F_STORE, F_ILLEGAL or F_NONE
task automatic build_table();
  // Arithmetic, back to back
  add_row(32'h002081B3, 1, 0, 0, 0, 0, FU_ARITH, ALU_ADD, F_WEN);
  add_row(32'h40208233, 1, 0, 0, 0, 0, FU_ARITH, ALU_SUB, F_WEN);
  add_row(32'hFFC08293, 1, 0, 0, 0, 0, FU_ARITH, ALU_ADD, F_WEN);
  add_row(32'h00309313, 1, 0, 0, 0, 0, FU_ARITH, ALU_SLL, F_WEN);
  add_row(32'h4020D393, 1, 0, 0, 0, 0, FU_ARITH, ALU_SRA, F_WEN);
  add_row(32'h12345437, 1, 0, 0, 0, 0, FU_ARITH, ALU_ADD, F_WEN);
  add_row(32'h00001497, 1, 0, 0, 0, 0, FU_ARITH, ALU_ADD, F_WEN);
  // Memory, jumps and branches
  add_row(32'h00812503, 1, 0, 0, 0, 0, FU_LOADSTORE, ALU_ADD, F_WEN | F_LOAD);
  add_row(32'h00312623, 1, 0, 0, 0, 0, FU_LOADSTORE, ALU_ADD, F_STORE);
  add_row(32'h010000EF, 1, 0, 0, 0, 0, FU_ARITH, ALU_ADD, F_WEN | F_JUMP);
  add_row(32'h00408067, 1, 0, 0, 0, 0, FU_ARITH, ALU_ADD, F_JUMP);
  add_row(32'h00208463, 1, 0, 0, 0, 0, FU_ARITH, ALU_ADD, F_BRANCH);
  add_row(32'hFE20CCE3, 1, 0, 0, 0, 0, FU_ARITH, ALU_ADD, F_BRANCH);
  // Illegal opcode takes no index
  add_row(32'h0000007F, 1, 0, 0, 0, 0, FU_NONE, ALU_ADD, F_ILLEGAL);
  // Stall holds, strobe under stall is dropped
  add_row(32'h002081B3, 1, 0, 1, 0, 0, FU_ARITH, ALU_ADD, F_WEN);
  add_row(32'h00000000, 0, 0, 1, 0, 0, FU_NONE, ALU_ADD, F_NONE);
  add_row(32'h002081B3, 1, 0, 0, 0, 0, FU_ARITH, ALU_ADD, F_WEN);
  // Flush beats a valid strobe
  add_row(32'h002081B3, 1, 1, 0, 0, 0, FU_ARITH, ALU_ADD, F_WEN);
  add_row(32'h00000000, 0, 0, 0, 0, 0, FU_NONE, ALU_ADD, F_NONE);
  // Two fence.i in a row, then acks in either order
  add_row(32'h0000100F, 1, 0, 0, 0, 0, FU_NONE, ALU_ADD, F_NONE);
  add_row(32'h0000100F, 1, 0, 0, 0, 0, FU_NONE, ALU_ADD, F_NONE);
  add_row(32'h00000000, 0, 0, 0, 1, 0, FU_NONE, ALU_ADD, F_NONE);
  add_row(32'h00000000, 0, 0, 0, 0, 0, FU_NONE, ALU_ADD, F_NONE);
  add_row(32'h00000000, 0, 0, 0, 0, 1, FU_NONE, ALU_ADD, F_NONE);
  add_row(32'hFFC08293, 1, 0, 0, 0, 0, FU_ARITH, ALU_ADD, F_WEN);
  add_row(32'h0000100F, 1, 0, 0, 0, 1, FU_NONE, ALU_ADD, F_NONE);
  add_row(32'h00000000, 0, 0, 0, 0, 1, FU_NONE, ALU_ADD, F_NONE);
  add_row(32'h00000000, 0, 0, 0, 1, 0, FU_NONE, ALU_ADD, F_NONE);
  add_row(32'h00000000, 0, 0, 0, 0, 0, FU_NONE, ALU_ADD, F_NONE);
  // Enough dispatches to wrap the tail
  add_row(32'h40208233, 1, 0, 0, 0, 0, FU_ARITH, ALU_SUB, F_WEN);
  add_row(32'h40208233, 1, 0, 0, 0, 0, FU_ARITH, ALU_SUB, F_WEN);
  add_row(32'h40208233, 1, 0, 0, 0, 0, FU_ARITH, ALU_SUB, F_WEN);
  add_row(32'h40208233, 1, 0, 0, 0, 0, FU_ARITH, ALU_SUB, F_WEN);
  add_row(32'h00000000, 0, 0, 0, 0, 0, FU_NONE, ALU_ADD, F_NONE);
endtask

`endif

/* verif/decode_stage_tb.sv */
// One table row per clock cycle, expected values from a cycle model of the stage
`timescale 1ns/10ps
`include "decode_defines.svh"

module decode_stage_tb
  import rv32i_isa_pkg::*, dispatch_pkg::*;
();

  localparam logic [5:0] F_NONE    = 6'b000000;
  localparam logic [5:0] F_WEN     = 6'b100000;
  localparam logic [5:0] F_JUMP    = 6'b010000;
  localparam logic [5:0] F_BRANCH  = 6'b001000;
  localparam logic [5:0] F_LOAD    = 6'b000100;
  localparam logic [5:0] F_STORE   = 6'b000010;
  localparam logic [5:0] F_ILLEGAL = 6'b000001;

  typedef struct packed {
    instr_t     instr;
    logic       valid, flush, stall, idone, ddone;
    fu_t        fu;
    alu_op_t    alu;
    logic [5:0] flags;
  } row_t;

  logic CLK, nRST, instr_valid, flush, stall_ex, iflush_done, dflush_done;
  instr_t instr;
  word_t pc, pc4, rs1_data, rs2_data;
  reg_addr_t rs1_addr, rs2_addr, rd;
  logic dispatch_valid, wen, is_jump, is_branch, is_load, is_store, illegal;
  logic cache_flush, fence_busy;
  fu_t fu;
  alu_op_t alu_op;
  branch_t branch_type;
  cb_index_t cb_index;
  word_t port_a, port_b, store_data, br_imm, wdata, j_base, j_offset, dispatch_pc;

  row_t rows[$];
  integer seed = 60427;
  integer pass_cnt = 0;
  integer fail_cnt = 0;
  logic row_bad;
  logic table_ready = 1'b0;

  // Cycle model state
  logic m_valid, m_last_fence, m_iflushed, m_dflushed;
  fu_t m_fu;
  alu_op_t m_alu;
  logic [5:0] m_flags;
  logic [2:0] m_btype;
  reg_addr_t m_rd;
  cb_index_t m_cb, m_tail;
  word_t m_pa, m_pb, m_store, m_brimm, m_wdata, m_jbase, m_joff, m_pc;

  decode_stage dut (.*);

  // Register file model
  assign rs1_data = 32'h1000_0000 + word_t'(rs1_addr);
  assign rs2_data = 32'h1000_0000 + word_t'(rs2_addr);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  task automatic add_row(input instr_t ins, input logic v, input logic fl, input logic st,
                         input logic idn, input logic ddn, input fu_t f, input alu_op_t a,
                         input logic [5:0] flg);
    row_t r;
    r = '{ins, v, fl, st, idn, ddn, f, a, flg};
    rows.push_back(r);
  endtask

  `include "decode_vectors.svh"

  task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAIL %0t: %s is %h, expected %h", $time, name, got, exp);
      row_bad = 1'b1;
    end
  endtask

  task automatic clear_model();
    m_valid = 1'b0;
    m_fu    = FU_NONE;
    m_alu   = ALU_ADD;
    m_flags = F_NONE;
    m_btype = 3'b000;
    m_cb    = '0;
    m_rd    = '0;
    m_pa    = '0;
    m_pb    = '0;
    m_store = '0;
    m_brimm = '0;
    m_wdata = '0;
    m_jbase = '0;
    m_joff  = '0;
    m_pc    = '0;
  endtask

  // Checks the combinational outputs, then advances the model by one edge
  task automatic step_model(input row_t r);
    logic [6:0] opc;
    logic [2:0] f3;
    logic fence_i, seen, acc, clr, cf;
    word_t rs1v, rs2v, ii, is, ib, iu, ij;
    opc  = r.instr[6:0];
    f3   = r.instr[14:12];
    rs1v = 32'h1000_0000 + word_t'(r.instr[19:15]);
    rs2v = 32'h1000_0000 + word_t'(r.instr[24:20]);
    ii   = word_t'($signed(r.instr) >>> 20);
    is   = {ii[31:5], r.instr[11:7]};
    ib   = {{20{r.instr[31]}}, r.instr[7], r.instr[30:25], r.instr[11:8], 1'b0};
    iu   = {r.instr[31:12], 12'h000};
    ij   = {{12{r.instr[31]}}, r.instr[19:12], r.instr[20], r.instr[30:21], 1'b0};
    fence_i = (opc == `OPC_MISC_MEM) && (f3 == 3'b001);
    seen = r.valid & ~r.stall & fence_i;
    cf   = seen & ~m_last_fence;
    acc  = r.valid & ~r.stall & ~r.flush & ~fence_i;
    clr  = r.flush | (~acc & ~r.stall);
    check_field("rs1_addr", rs1_addr, r.instr[19:15]);
    check_field("rs2_addr", rs2_addr, r.instr[24:20]);
    check_field("cache_flush", cache_flush, cf);
    if (clr) begin
      clear_model();
    end else if (acc) begin
      m_valid = 1'b1;
      m_fu    = r.fu;
      m_alu   = r.alu;
      m_flags = r.flags;
      m_btype = f3;
      m_cb    = m_tail;
      m_rd    = r.instr[11:7];
      m_store = rs2v;
      m_brimm = ib;
      m_pc    = pc;
      m_pa    = (opc == `OPC_STORE) ? is : (opc == `OPC_AUIPC) ? pc : rs1v;
      case (opc)
        `OPC_OP_IMM: m_pb = (f3 == 3'b001 || f3 == 3'b101) ? word_t'(r.instr[24:20]) : ii;
        `OPC_LOAD: m_pb = ii;
        `OPC_STORE: m_pb = rs1v;
        `OPC_LUI, `OPC_AUIPC: m_pb = iu;
        default: m_pb = rs2v;
      endcase
      m_wdata = (opc == `OPC_JAL || opc == `OPC_JALR) ? pc4 : (opc == `OPC_LUI) ? iu : '0;
      m_jbase = (opc == `OPC_JAL) ? pc : m_pa;
      m_joff  = (opc == `OPC_JAL) ? ij : ii;
      if (r.fu != FU_NONE) m_tail = m_tail + 1'b1;
    end
    if (cf) begin
      m_iflushed = 1'b0;
      m_dflushed = 1'b0;
    end else begin
      m_iflushed = m_iflushed | r.idone;
      m_dflushed = m_dflushed | r.ddone;
    end
    m_last_fence = seen;
  endtask

  task automatic finish_row(input integer idx);
    check_field("dispatch_valid", dispatch_valid, m_valid);
    check_field("fu", fu, m_fu);
    check_field("alu_op", alu_op, m_alu);
    check_field("flags", {wen, is_jump, is_branch, is_load, is_store, illegal}, m_flags);
    check_field("branch_type", branch_type, m_btype);
    check_field("cb_index", cb_index, m_cb);
    check_field("rd", rd, m_rd);
    check_field("port_a", port_a, m_pa);
    check_field("port_b", port_b, m_pb);
    check_field("store_data", store_data, m_store);
    check_field("br_imm", br_imm, m_brimm);
    check_field("wdata", wdata, m_wdata);
    check_field("j_base", j_base, m_jbase);
    check_field("j_offset", j_offset, m_joff);
    check_field("dispatch_pc", dispatch_pc, m_pc);
    check_field("fence_busy", fence_busy, !(m_iflushed && m_dflushed));
    if (row_bad) fail_cnt++;
    else pass_cnt++;
    $display("row %0d: %s", idx, row_bad ? "mismatch" : "ok");
    row_bad = 1'b0;
  endtask

  initial begin
    nRST = 1'b0;
    instr_valid = 1'b0;
    instr = '0;
    pc = '0;
    pc4 = 32'd4;
    flush = 1'b0;
    stall_ex = 1'b0;
    iflush_done = 1'b0;
    dflush_done = 1'b0;
    row_bad = 1'b0;
    clear_model();
    m_tail = '0;
    m_last_fence = 1'b0;
    m_iflushed = 1'b1;
    m_dflushed = 1'b1;
    build_table();
    table_ready = 1'b1;
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    for (int i = 0; i < rows.size(); i++) begin
      @(negedge CLK);
      if (i > 0) finish_row(i - 1);
      instr_valid = rows[i].valid;
      instr       = rows[i].instr;
      flush       = rows[i].flush;
      stall_ex    = rows[i].stall;
      iflush_done = rows[i].idone;
      dflush_done = rows[i].ddone;
      pc          = word_t'($random(seed)) & 32'hFFFF_FFFC;
      pc4         = pc + 32'd4;
      #1;
      step_model(rows[i]);
    end
    @(negedge CLK);
    finish_row(rows.size() - 1);
    $display("Summary: %0d rows passed, %0d rows failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    integer limit;
    wait (table_ready);
    limit = (rows.size() + 3) * 10 + 200;
    #(limit);
    $display("Timeout: the run did not finish within %0d ns", limit);
    $display("Test failed");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+common
+incdir+verif
common/rv32i_isa_pkg.sv
common/dispatch_pkg.sv
common/decode_ctrl_if.sv
decode/instr_decoder.sv
decode/operand_select.sv
decode/dispatch_latch.sv
decode/fence_tracker.sv
rtl/decode_stage.sv
verif/decode_stage_tb.sv
